// File: rtl/async_fifo_config.svh
`ifndef ASYNC_FIFO_CONFIG_SVH
`define ASYNC_FIFO_CONFIG_SVH

// data word width.
`define FIFO_DATA_WIDTH 8

// ram address width, depth is 2**FIFO_ADDR_WIDTH.
`define FIFO_ADDR_WIDTH 4
`define FIFO_DEPTH      16

// flag thresholds in words.
`define FIFO_AFULL      12
`define FIFO_AEMPTY     2

`endif

// File: rtl/async_fifo_pkg.sv
`include "async_fifo_config.svh"

package async_fifo_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;   // one stored word.
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;   // ram index.
  typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_ptr_t;    // pointer with wrap bit.
  typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_count_t;  // 0 .. FIFO_DEPTH.

  //////////////////////////////////////////////////////////////////////
  // pointer decode
  //////////////////////////////////////////////////////////////////////

  // gray to binary, msb passes through, each lower bit folds in the one above.
  function automatic fifo_ptr_t gray2bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: rtl/dualport_ram_async.sv
`timescale 1ns/1ns
`include "async_fifo_config.svh"

module dualport_ram_async (
  input  logic                       wr_clk,
  input  logic                       wr_en,
  input  async_fifo_pkg::fifo_addr_t wr_addr,
  input  async_fifo_pkg::fifo_data_t wr_data,
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_en,
  input  async_fifo_pkg::fifo_addr_t rd_addr,
  output async_fifo_pkg::fifo_data_t rd_data
);

  async_fifo_pkg::fifo_data_t mem [`FIFO_DEPTH];  // storage, no reset.

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;  // stored at the write edge.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registered read port
  //////////////////////////////////////////////////////////////////////

  // word held until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];  // one cycle latency.
    end
  end

endmodule

// File: rtl/ptr_sync.sv
`timescale 1ns/1ns

module ptr_sync (
  input  logic                      clk,
  input  logic                      rst_n,
  input  async_fifo_pkg::fifo_ptr_t gray_in,
  output async_fifo_pkg::fifo_ptr_t gray_out
);

  async_fifo_pkg::fifo_ptr_t meta;  // first stage, may go metastable.

  // only one bit of a gray pointer changes per step, so a late sample
  // lands on either the old or the new value.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta     <= '0;
      gray_out <= '0;
    end else begin
      meta     <= gray_in;
      gray_out <= meta;  // settled copy.
    end
  end

endmodule

// File: rtl/fifo_wr_ctrl.sv
`timescale 1ns/1ns
`include "async_fifo_config.svh"

module fifo_wr_ctrl (
  input  logic                       wr_clk,
  input  logic                       wr_rst_n,
  input  logic                       wr_en,
  input  async_fifo_pkg::fifo_ptr_t  rd_gray_sync,
  output logic                       wr_vld,
  output async_fifo_pkg::fifo_addr_t wr_addr,
  output async_fifo_pkg::fifo_ptr_t  wr_gray,
  output logic                       full,
  output logic                       afull
);

  async_fifo_pkg::fifo_ptr_t   wr_ptr;
  async_fifo_pkg::fifo_ptr_t   wr_ptr_nxt;
  async_fifo_pkg::fifo_ptr_t   wr_gray_nxt;
  async_fifo_pkg::fifo_ptr_t   rd_ptr_sync;   // decoded read pointer.
  async_fifo_pkg::fifo_ptr_t   rd_gray_full;  // read pointer one lap ahead.
  async_fifo_pkg::fifo_count_t fill_level;

  //////////////////////////////////////////////////////////////////////
  // write pointer
  //////////////////////////////////////////////////////////////////////

  assign wr_vld  = wr_en & ~full;  // writes while full are dropped.
  assign wr_addr = wr_ptr[`FIFO_ADDR_WIDTH-1:0];

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= wr_gray_nxt;  // feeds the read-side synchronizer.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////

  // in gray, a full lap differs in the two top bits only.
  assign rd_gray_full = {~rd_gray_sync[`FIFO_ADDR_WIDTH -: 2],
                         rd_gray_sync[`FIFO_ADDR_WIDTH-2:0]};

  assign rd_ptr_sync = async_fifo_pkg::gray2bin(rd_gray_sync);
  assign fill_level  = wr_ptr_nxt - rd_ptr_sync;  // stale read ptr, never low.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_gray_nxt == rd_gray_full);
      afull <= (fill_level >= async_fifo_pkg::fifo_count_t'(`FIFO_AFULL));
    end
  end

endmodule

// File: rtl/fifo_rd_ctrl.sv
`timescale 1ns/1ns
`include "async_fifo_config.svh"

module fifo_rd_ctrl (
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_en,
  input  async_fifo_pkg::fifo_ptr_t  wr_gray_sync,
  output logic                       rd_vld,
  output async_fifo_pkg::fifo_addr_t rd_addr,
  output async_fifo_pkg::fifo_ptr_t  rd_gray,
  output logic                       empty,
  output logic                       aempty
);

  async_fifo_pkg::fifo_ptr_t   rd_ptr;
  async_fifo_pkg::fifo_ptr_t   rd_ptr_nxt;
  async_fifo_pkg::fifo_ptr_t   rd_gray_nxt;
  async_fifo_pkg::fifo_ptr_t   wr_ptr_sync;  // decoded write pointer.
  async_fifo_pkg::fifo_count_t fill_level;

  //////////////////////////////////////////////////////////////////////
  // read pointer
  //////////////////////////////////////////////////////////////////////

  assign rd_vld  = rd_en & ~empty;  // reads while empty are ignored.
  assign rd_addr = rd_ptr[`FIFO_ADDR_WIDTH-1:0];

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= rd_gray_nxt;  // feeds the write-side synchronizer.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////

  assign wr_ptr_sync = async_fifo_pkg::gray2bin(wr_gray_sync);
  assign fill_level  = wr_ptr_sync - rd_ptr_nxt;  // stale write ptr, never high.

  // empty and aempty come out of reset set.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_gray_nxt == wr_gray_sync);
      aempty <= (fill_level <= async_fifo_pkg::fifo_count_t'(`FIFO_AEMPTY));
    end
  end

endmodule

// File: rtl/async_fifo.sv
`timescale 1ns/1ns

module async_fifo (
  input  logic                       wr_clk,
  input  logic                       wr_rst_n,
  input  logic                       wr_en,
  input  async_fifo_pkg::fifo_data_t wr_data,
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_en,
  output async_fifo_pkg::fifo_data_t rd_data,
  output logic                       full,
  output logic                       empty,
  output logic                       afull,
  output logic                       aempty
);

  logic                       wr_vld;
  async_fifo_pkg::fifo_addr_t wr_addr;
  async_fifo_pkg::fifo_ptr_t  wr_gray;
  async_fifo_pkg::fifo_ptr_t  rd_gray_sync;  // read ptr seen by wr_clk.

  logic                       rd_vld;
  async_fifo_pkg::fifo_addr_t rd_addr;
  async_fifo_pkg::fifo_ptr_t  rd_gray;
  async_fifo_pkg::fifo_ptr_t  wr_gray_sync;  // write ptr seen by rd_clk.

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  dualport_ram_async u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // write domain
  //////////////////////////////////////////////////////////////////////

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_vld       (wr_vld),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  ptr_sync u_rd2wr (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  //////////////////////////////////////////////////////////////////////
  // read domain
  //////////////////////////////////////////////////////////////////////

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_vld       (rd_vld),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  ptr_sync u_wr2rd (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

endmodule

// File: verification/async_fifo_tb.sv
`timescale 1ns/1ns
`include "async_fifo_config.svh"

module async_fifo_tb;

  localparam int          WAIT_LIMIT   = 50;
  localparam int          STREAM_WORDS = 200;
  localparam int          STREAM_LIMIT = 4000;  // cycles per side.
  localparam logic [31:0] LFSR_TAPS    = 32'hB4BCD35C;

  logic                       wr_clk;
  logic                       wr_rst_n;
  logic                       wr_en;
  async_fifo_pkg::fifo_data_t wr_data;
  logic                       rd_clk;
  logic                       rd_rst_n;
  logic                       rd_en;
  async_fifo_pkg::fifo_data_t rd_data;
  logic                       full;
  logic                       empty;
  logic                       afull;
  logic                       aempty;

  async_fifo_pkg::fifo_data_t ref_q[$];  // accepted writes in order.
  async_fifo_pkg::fifo_data_t last_read;
  logic [31:0]                lfsr_state;
  int                         errors;

  async_fifo u_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #20 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #28 rd_clk = ~rd_clk;  // drifts against wr_clk.
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic async_fifo_pkg::fifo_data_t random_word();
    async_fifo_pkg::fifo_data_t w;
    for (int i = 0; i < `FIFO_DATA_WIDTH; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  task automatic check_data(input string name, input async_fifo_pkg::fifo_data_t exp,
                            input async_fifo_pkg::fifo_data_t act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input async_fifo_pkg::fifo_count_t exp,
                             input async_fifo_pkg::fifo_count_t act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  // returns on a falling rd_clk edge.
  task automatic wait_empty(input logic value);
    int cycles;
    cycles = 0;
    do begin
      @(negedge rd_clk);
      cycles++;
    end while (empty !== value && cycles < WAIT_LIMIT);
    if (empty !== value) begin
      $display("timeout: empty did not become %0b within %0d read cycles", value, WAIT_LIMIT);
      errors++;
    end
  endtask

  // lets both pointers cross and the flags register.
  task automatic settle();
    repeat (6) @(negedge rd_clk);
    repeat (6) @(negedge wr_clk);
  endtask

  task automatic write_word(input async_fifo_pkg::fifo_data_t data);
    @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = data;
    if (!full) begin
      ref_q.push_back(data);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic read_check();
    async_fifo_pkg::fifo_data_t exp;
    wait_empty(1'b0);
    if (empty || ref_q.size() == 0) begin
      $display("no word available for a read");
      errors++;
      return;
    end
    exp   = ref_q.pop_front();
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    check_data("rd_data", exp, rd_data);
    last_read = exp;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    check_data("rd_data", '0, rd_data);
  endtask

  task automatic test_single();
    write_word(random_word());
    read_check();
    wait_empty(1'b1);
    settle();
  endtask

  task automatic test_fill_full();
    int accepted;
    int cycles;
    accepted = 0;
    cycles   = 0;
    @(negedge wr_clk);
    while (!full && cycles < WAIT_LIMIT) begin
      wr_en   = 1'b1;
      wr_data = random_word();
      ref_q.push_back(wr_data);
      accepted++;
      @(negedge wr_clk);
      cycles++;
    end
    wr_en = 1'b0;
    if (!full) begin
      $display("timeout: full did not rise within %0d write cycles", WAIT_LIMIT);
      errors++;
    end
    check_count("accepted writes", `FIFO_DEPTH, async_fifo_pkg::fifo_count_t'(accepted));
    // one more word while full is lost.
    wr_en   = 1'b1;
    wr_data = random_word();
    @(negedge wr_clk);
    wr_en = 1'b0;
    check_flag("full", 1'b1, full);
    repeat (`FIFO_DEPTH) read_check();
    settle();
    check_flag("empty", 1'b1, empty);
  endtask

  task automatic test_underflow();
    wait_empty(1'b1);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    @(negedge rd_clk);
    check_data("rd_data", last_read, rd_data);
    check_flag("empty", 1'b1, empty);
  endtask

  task automatic test_thresholds();
    int level;
    int targets[4];
    targets = '{`FIFO_AEMPTY, `FIFO_AEMPTY + 1, `FIFO_AFULL - 1, `FIFO_AFULL};
    level   = 0;
    foreach (targets[i]) begin
      while (level < targets[i]) begin
        write_word(random_word());
        level++;
      end
      settle();
      check_flag("afull", level >= `FIFO_AFULL, afull);
      check_flag("aempty", level <= `FIFO_AEMPTY, aempty);
    end
    while (ref_q.size() > 0) begin
      read_check();
    end
    wait_empty(1'b1);
    settle();
  endtask

  task automatic test_stream();
    int                         wr_done;
    int                         rd_done;
    int                         wr_cycles;
    int                         rd_cycles;
    logic                       pending;
    async_fifo_pkg::fifo_data_t exp;
    wr_done   = 0;
    rd_done   = 0;
    wr_cycles = 0;
    rd_cycles = 0;
    pending   = 1'b0;
    exp       = '0;
    fork
      begin : writer
        while (wr_done < STREAM_WORDS && wr_cycles < STREAM_LIMIT) begin
          @(negedge wr_clk);
          wr_cycles++;
          wr_en   = lfsr_bit();
          wr_data = random_word();
          if (wr_en && !full) begin
            ref_q.push_back(wr_data);
            wr_done++;
          end
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
      end
      begin : reader
        while ((rd_done < STREAM_WORDS || pending) && rd_cycles < STREAM_LIMIT) begin
          @(negedge rd_clk);
          rd_cycles++;
          if (pending) begin
            check_data("rd_data", exp, rd_data);
            pending = 1'b0;
          end
          if (rd_done < STREAM_WORDS) begin
            rd_en = lfsr_bit();
            if (rd_en && !empty) begin
              if (ref_q.size() == 0) begin
                $display("read accepted while no word was written");
                errors++;
              end else begin
                exp     = ref_q.pop_front();
                pending = 1'b1;
              end
              rd_done++;
            end
          end else begin
            rd_en = 1'b0;
          end
        end
        rd_en = 1'b0;
      end
    join
    if (wr_done < STREAM_WORDS || rd_done < STREAM_WORDS) begin
      $display("stream stalled after %0d writes and %0d reads", wr_done, rd_done);
      errors++;
    end
    wait_empty(1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    wr_rst_n   = 1'b0;
    rd_rst_n   = 1'b0;
    wr_en      = 1'b0;
    wr_data    = '0;
    rd_en      = 1'b0;
    lfsr_state = 32'd66311;
    last_read  = '0;
    errors     = 0;
    fork
      begin
        repeat (3) @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (3) @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join
    settle();

    test_reset();
    test_single();
    test_fill_full();
    test_underflow();
    test_thresholds();
    test_stream();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: async_fifo.f
+incdir+rtl
rtl/async_fifo_pkg.sv
rtl/dualport_ram_async.sv
rtl/ptr_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
verification/async_fifo_tb.sv

// File: Makefile
TOP := async_fifo_tb

sim:
	verilator --binary --timing --timescale 1ns/1ns -f async_fifo.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
